// File: hw/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////

    localparam int xlen = 32;

    // Operand and result word
    typedef logic [xlen-1:0] word_t;

    // Physical destination register tag
    typedef logic [7:0] preg_t;

    // Program counter of the issuing instruction
    typedef logic [31:0] pc_t;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////

    // Bit 1 picks the unit (0 is the divider, 1 the multiplier)
    // Bit 0 picks the result word within that unit
    typedef enum logic [1:0] {
        op_divu  = 2'b00,
        op_remu  = 2'b01,
        op_mul   = 2'b10,
        op_mulhu = 2'b11
    } op_t;

    ////////////////////////////////////////////////////////////
    // Pipeline depths and queue sizing
    ////////////////////////////////////////////////////////////

    // One register row after every second restoring step
    localparam int div_latency = 16;

    localparam int mul_latency = 3;

    localparam int queue_depth = 4;

    // Counts 0 to queue_depth inclusive
    typedef logic [2:0] queue_count_t;

endpackage

`default_nettype wire

// File: hw/pipe_divider.sv
`default_nettype none

module pipe_divider
    import muldiv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  word_t a,
    input  word_t b,
    input  op_t   op,
    input  preg_t tag_in,
    input  pc_t   pc_in,
    output logic  done,
    output word_t result,
    output preg_t tag_out,
    output pc_t   pc_out,
    output logic  divide_zero
);

    // One restoring step. The quotient register starts out holding the
    // dividend, which shifts out at the top while quotient bits shift in
    // at the bottom. Returns the new partial remainder and quotient
    function automatic logic [2*xlen-1:0] div_step(
        input word_t rem,
        input word_t quo,
        input word_t den
    );
        logic [xlen:0]   shifted;
        logic [xlen+1:0] diff;
        logic            fits;
        begin
            shifted = {rem, quo[xlen-1]};
            diff    = {1'b0, shifted} - {2'b00, den};
            fits    = !diff[xlen+1];
            if (fits) begin
                div_step = {diff[xlen-1:0], quo[xlen-2:0], 1'b1};
            end else begin
                div_step = {shifted[xlen-1:0], quo[xlen-2:0], 1'b0};
            end
        end
    endfunction

    // Row 0 is the input side, row div_latency is the output side
    logic  row_valid [0:div_latency];
    word_t row_rem   [0:div_latency];
    word_t row_quo   [0:div_latency];
    word_t row_den   [0:div_latency];
    op_t   row_op    [0:div_latency];
    preg_t row_tag   [0:div_latency];
    pc_t   row_pc    [0:div_latency];
    logic  row_dz    [0:div_latency];

    assign row_valid[0] = start;
    assign row_rem[0]   = '0;
    assign row_quo[0]   = a;
    assign row_den[0]   = b;
    assign row_op[0]    = op;
    assign row_tag[0]   = tag_in;
    assign row_pc[0]    = pc_in;
    // A zero dividend over a zero divisor is not flagged
    assign row_dz[0]    = (a != '0) && (b == '0);

    ////////////////////////////////////////////////////////////
    // Two steps per register row
    ////////////////////////////////////////////////////////////

    for (genvar s = 0; s < div_latency; s++) begin : g_stage
        logic [2*xlen-1:0] step_lo;
        logic [2*xlen-1:0] step_hi;
        logic              valid_q;
        word_t             rem_q;
        word_t             quo_q;
        word_t             den_q;
        op_t               op_q;
        preg_t             tag_q;
        pc_t               pc_q;
        logic              dz_q;

        assign step_lo = div_step(row_rem[s], row_quo[s], row_den[s]);
        assign step_hi = div_step(step_lo[2*xlen-1:xlen], step_lo[xlen-1:0], row_den[s]);

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= row_valid[s];
            end
        end

        always_ff @(posedge clk) begin
            rem_q <= step_hi[2*xlen-1:xlen];
            quo_q <= step_hi[xlen-1:0];
            den_q <= row_den[s];
            op_q  <= row_op[s];
            tag_q <= row_tag[s];
            pc_q  <= row_pc[s];
            dz_q  <= row_dz[s];
        end

        assign row_valid[s+1] = valid_q;
        assign row_rem[s+1]   = rem_q;
        assign row_quo[s+1]   = quo_q;
        assign row_den[s+1]   = den_q;
        assign row_op[s+1]    = op_q;
        assign row_tag[s+1]   = tag_q;
        assign row_pc[s+1]    = pc_q;
        assign row_dz[s+1]    = dz_q;
    end

    // With a zero divisor every step fits, so the quotient comes out all
    // ones and the remainder ends up equal to the dividend
    assign done        = row_valid[div_latency];
    assign result      = (row_op[div_latency] == op_divu) ? row_quo[div_latency]
                                                          : row_rem[div_latency];
    assign tag_out     = row_tag[div_latency];
    assign pc_out      = row_pc[div_latency];
    assign divide_zero = row_dz[div_latency];

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_done_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(done)
    );

endmodule

`default_nettype wire

// File: hw/pipe_multiplier.sv
`default_nettype none

module pipe_multiplier
    import muldiv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  word_t a,
    input  word_t b,
    input  op_t   op,
    input  preg_t tag_in,
    input  pc_t   pc_in,
    output logic  done,
    output word_t result,
    output preg_t tag_out,
    output pc_t   pc_out
);

    // Stage 1 holds the operands
    logic  s1_valid;
    word_t s1_a;
    word_t s1_b;
    op_t   s1_op;
    preg_t s1_tag;
    pc_t   s1_pc;

    // Stage 2 holds the full product
    logic              s2_valid;
    logic [2*xlen-1:0] s2_prod;
    op_t               s2_op;
    preg_t             s2_tag;
    pc_t               s2_pc;

    // Stage 3 holds the selected word
    logic  s3_valid;
    word_t s3_result;
    preg_t s3_tag;
    pc_t   s3_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= start;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_a   <= a;
        s1_b   <= b;
        s1_op  <= op;
        s1_tag <= tag_in;
        s1_pc  <= pc_in;

        s2_prod <= {{xlen{1'b0}}, s1_a} * {{xlen{1'b0}}, s1_b};
        s2_op   <= s1_op;
        s2_tag  <= s1_tag;
        s2_pc   <= s1_pc;

        // mulhu takes the upper half, mul the lower
        s3_result <= (s2_op == op_mulhu) ? s2_prod[2*xlen-1:xlen] : s2_prod[xlen-1:0];
        s3_tag    <= s2_tag;
        s3_pc     <= s2_pc;
    end

    assign done    = s3_valid;
    assign result  = s3_result;
    assign tag_out = s3_tag;
    assign pc_out  = s3_pc;

endmodule

`default_nettype wire

// File: hw/result_queue.sv
`default_nettype none

module result_queue
    import muldiv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  reserve,
    input  logic  push,
    input  word_t push_data,
    input  preg_t push_tag,
    input  pc_t   push_pc,
    input  logic  push_exc,
    input  logic  pop,
    output logic  not_empty,
    output word_t head_data,
    output preg_t head_tag,
    output pc_t   head_pc,
    output logic  head_exc,
    output logic  credit
);

    word_t mem_data [0:queue_depth-1];
    preg_t mem_tag  [0:queue_depth-1];
    pc_t   mem_pc   [0:queue_depth-1];
    logic  mem_exc  [0:queue_depth-1];

    logic [$clog2(queue_depth)-1:0] wr_ptr;
    logic [$clog2(queue_depth)-1:0] rd_ptr;
    queue_count_t                   fill_count;
    // Entries still in the unit plus entries waiting here
    queue_count_t                   resv_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_count <= '0;
            resv_count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            fill_count <= fill_count + queue_count_t'(push) - queue_count_t'(pop);
            resv_count <= resv_count + queue_count_t'(reserve) - queue_count_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr] <= push_data;
            mem_tag[wr_ptr]  <= push_tag;
            mem_pc[wr_ptr]   <= push_pc;
            mem_exc[wr_ptr]  <= push_exc;
        end
    end

    assign not_empty = (fill_count != '0);
    assign head_data = mem_data[rd_ptr];
    assign head_tag  = mem_tag[rd_ptr];
    assign head_pc   = mem_pc[rd_ptr];
    assign head_exc  = mem_exc[rd_ptr];
    assign credit    = (resv_count < queue_count_t'(queue_depth));

    // A push into a full queue means the issue credits were overrun
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset) push |-> fill_count != queue_count_t'(queue_depth)
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset) pop |-> fill_count != '0
    );

endmodule

`default_nettype wire

// File: hw/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter
    import muldiv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  div_valid,
    input  word_t div_data,
    input  preg_t div_tag,
    input  pc_t   div_pc,
    input  logic  div_exc,
    input  logic  mul_valid,
    input  word_t mul_data,
    input  preg_t mul_tag,
    input  pc_t   mul_pc,
    input  logic  mul_exc,
    input  logic  cdb_ready,
    output logic  div_pop,
    output logic  mul_pop,
    output logic  cdb_valid,
    output preg_t cdb_tag,
    output pc_t   cdb_pc,
    output word_t cdb_data,
    output logic  cdb_exception
);

    // Set when the multiplier has priority in a contested cycle
    logic prio_mul;
    // A stalled grant is held so the bus does not change under the sink
    logic locked;
    logic locked_mul;
    logic sel_mul;
    logic xfer;

    assign sel_mul = locked ? locked_mul : (mul_valid && (!div_valid || prio_mul));

    assign cdb_valid     = sel_mul ? mul_valid : div_valid;
    assign cdb_tag       = sel_mul ? mul_tag : div_tag;
    assign cdb_pc        = sel_mul ? mul_pc : div_pc;
    assign cdb_data      = sel_mul ? mul_data : div_data;
    assign cdb_exception = sel_mul ? mul_exc : div_exc;

    assign xfer    = cdb_valid && cdb_ready;
    assign div_pop = xfer && !sel_mul;
    assign mul_pop = xfer && sel_mul;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_mul   <= 1'b0;
            locked     <= 1'b0;
            locked_mul <= 1'b0;
        end else begin
            // Priority moves to the unit that did not win
            if (xfer) prio_mul <= !sel_mul;
            locked     <= cdb_valid && !cdb_ready;
            locked_mul <= sel_mul;
        end
    end

    a_one_pop: assert property (
        @(posedge clk) disable iff (reset) !(div_pop && mul_pop)
    );

    a_hold_stall: assert property (
        @(posedge clk) disable iff (reset)
        cdb_valid && !cdb_ready |=> cdb_valid && $stable(cdb_tag) && $stable(cdb_data)
    );

endmodule

`default_nettype wire

// File: hw/muldiv_cluster.sv
`default_nettype none

module muldiv_cluster
    import muldiv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  issue_valid,
    input  op_t   issue_op,
    input  word_t issue_a,
    input  word_t issue_b,
    input  preg_t issue_tag,
    input  pc_t   issue_pc,
    output logic  issue_div_ready,
    output logic  issue_mul_ready,
    output logic  cdb_valid,
    output preg_t cdb_tag,
    output pc_t   cdb_pc,
    output word_t cdb_data,
    output logic  cdb_exception,
    input  logic  cdb_ready
);

    logic  div_issue, mul_issue;
    logic  div_done, mul_done;
    word_t div_result, mul_result;
    preg_t div_tag, mul_tag;
    pc_t   div_pc, mul_pc;
    logic  div_zero;

    logic  qd_valid, qm_valid;
    word_t qd_data, qm_data;
    preg_t qd_tag, qm_tag;
    pc_t   qd_pc, qm_pc;
    logic  qd_exc, qm_exc;
    logic  qd_pop, qm_pop;

    // The top opcode bit names the unit, and only that unit's credit counts
    assign div_issue = issue_valid && !issue_op[1] && issue_div_ready;
    assign mul_issue = issue_valid && issue_op[1] && issue_mul_ready;

    pipe_divider u_div (
        .clk(clk), .reset(reset), .start(div_issue), .a(issue_a), .b(issue_b),
        .op(issue_op), .tag_in(issue_tag), .pc_in(issue_pc), .done(div_done),
        .result(div_result), .tag_out(div_tag), .pc_out(div_pc), .divide_zero(div_zero)
    );

    pipe_multiplier u_mul (
        .clk(clk), .reset(reset), .start(mul_issue), .a(issue_a), .b(issue_b),
        .op(issue_op), .tag_in(issue_tag), .pc_in(issue_pc), .done(mul_done),
        .result(mul_result), .tag_out(mul_tag), .pc_out(mul_pc)
    );

    result_queue q_div (
        .clk(clk), .reset(reset), .reserve(div_issue), .push(div_done),
        .push_data(div_result), .push_tag(div_tag), .push_pc(div_pc), .push_exc(div_zero),
        .pop(qd_pop), .not_empty(qd_valid), .head_data(qd_data), .head_tag(qd_tag),
        .head_pc(qd_pc), .head_exc(qd_exc), .credit(issue_div_ready)
    );

    // Multiplication raises no exception
    result_queue q_mul (
        .clk(clk), .reset(reset), .reserve(mul_issue), .push(mul_done),
        .push_data(mul_result), .push_tag(mul_tag), .push_pc(mul_pc), .push_exc(1'b0),
        .pop(qm_pop), .not_empty(qm_valid), .head_data(qm_data), .head_tag(qm_tag),
        .head_pc(qm_pc), .head_exc(qm_exc), .credit(issue_mul_ready)
    );

    cdb_arbiter u_arb (
        .clk(clk), .reset(reset),
        .div_valid(qd_valid), .div_data(qd_data), .div_tag(qd_tag), .div_pc(qd_pc),
        .div_exc(qd_exc),
        .mul_valid(qm_valid), .mul_data(qm_data), .mul_tag(qm_tag), .mul_pc(qm_pc),
        .mul_exc(qm_exc),
        .cdb_ready(cdb_ready), .div_pop(qd_pop), .mul_pop(qm_pop),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_pc(cdb_pc), .cdb_data(cdb_data),
        .cdb_exception(cdb_exception)
    );

endmodule

`default_nettype wire

// File: dv/tb_muldiv_cluster.sv
`default_nettype none

module tb_muldiv_cluster
    import muldiv_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ready_timeout = 200;
    localparam int drain_timeout = 400;

    // One expected CDB transfer
    typedef struct packed {
        preg_t tag;
        pc_t   pc;
        word_t data;
        logic  exc;
    } expect_t;

    logic  clk;
    logic  reset;
    logic  issue_valid;
    op_t   issue_op;
    word_t issue_a;
    word_t issue_b;
    preg_t issue_tag;
    pc_t   issue_pc;
    logic  issue_div_ready;
    logic  issue_mul_ready;
    logic  cdb_valid;
    preg_t cdb_tag;
    pc_t   cdb_pc;
    word_t cdb_data;
    logic  cdb_exception;
    logic  cdb_ready;

    // Scoreboards per unit that hold their entries in issue order
    expect_t div_expect_q [$];
    expect_t mul_expect_q [$];
    // Unit of each CDB transfer where 0 is the divider and 1 the multiplier
    int      xfer_units [$];

    logic [31:0] lfsr_state;
    preg_t       next_tag;
    string       cur_test;
    int          error_count;
    int          check_count;

    muldiv_cluster dut0 (
        .clk(clk), .reset(reset),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_a(issue_a),
        .issue_b(issue_b), .issue_tag(issue_tag), .issue_pc(issue_pc),
        .issue_div_ready(issue_div_ready), .issue_mul_ready(issue_mul_ready),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_pc(cdb_pc), .cdb_data(cdb_data),
        .cdb_exception(cdb_exception), .cdb_ready(cdb_ready)
    );

    always #10 clk = !clk;

    ////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////

    // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1 that steps once per bit
    function automatic word_t rand_word(input int nbits);
        word_t val;
        logic  fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Unsigned division where a zero divisor gives all ones and the dividend back
    function automatic word_t div_model(input op_t op, input word_t a, input word_t b);
        word_t quo;
        word_t rem;
        if (b == '0) begin
            quo = '1;
            rem = a;
        end else begin
            quo = a / b;
            rem = a % b;
        end
        return (op == op_divu) ? quo : rem;
    endfunction

    function automatic word_t mul_model(input op_t op, input word_t a, input word_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        return (op == op_mulhu) ? prod[63:32] : prod[31:0];
    endfunction

    function automatic logic unit_ready(input op_t op);
        return op[1] ? issue_mul_ready : issue_div_ready;
    endfunction

    task automatic next_cycle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Waits for the unit's credit, then holds the operation for one edge
    task automatic issue_one(input op_t op, input word_t a, input word_t b);
        expect_t entry;
        int      waited;
        entry.tag = next_tag;
        entry.pc  = 32'h0000_8000 + {22'b0, next_tag, 2'b00};
        if (op[1]) begin
            entry.data = mul_model(op, a, b);
            entry.exc  = 1'b0;
        end else begin
            entry.data = div_model(op, a, b);
            entry.exc  = (a != '0) && (b == '0);
        end
        waited = 0;
        while (!unit_ready(op) && waited < ready_timeout) begin
            next_cycle(1);
            waited++;
        end
        if (!unit_ready(op)) begin
            $display("%s: issue ready stayed low for %0d cycles", cur_test, waited);
            error_count++;
        end else begin
            issue_valid = 1'b1;
            issue_op    = op;
            issue_a     = a;
            issue_b     = b;
            issue_tag   = entry.tag;
            issue_pc    = entry.pc;
            if (op[1]) begin
                mul_expect_q.push_back(entry);
            end else begin
                div_expect_q.push_back(entry);
            end
            next_cycle(1);
            issue_valid = 1'b0;
            next_tag++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((div_expect_q.size() + mul_expect_q.size()) != 0 && waited < drain_timeout) begin
            next_cycle(1);
            waited++;
        end
        if ((div_expect_q.size() + mul_expect_q.size()) != 0) begin
            $display("%s: %0d results never reached the CDB", cur_test,
                     div_expect_q.size() + mul_expect_q.size());
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // CDB collector
    ////////////////////////////////////////////////////////////

    task automatic compare_field(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        assert (expected === actual) else begin
            $display("[ERROR] %s %s expected %h actual %h", cur_test, field, expected, actual);
            error_count++;
        end
    endtask

    // A tag matches only at the head of its unit's queue, so order is checked too
    task automatic check_transfer();
        expect_t entry;
        logic    found;
        found = 1'b0;
        if (div_expect_q.size() > 0 && div_expect_q[0].tag == cdb_tag) begin
            entry = div_expect_q.pop_front();
            found = 1'b1;
            xfer_units.push_back(0);
        end else if (mul_expect_q.size() > 0 && mul_expect_q[0].tag == cdb_tag) begin
            entry = mul_expect_q.pop_front();
            found = 1'b1;
            xfer_units.push_back(1);
        end
        check_count++;
        assert (found) else begin
            $display("%s: tag %h on the CDB was not the next one expected", cur_test, cdb_tag);
            error_count++;
        end
        if (found) begin
            compare_field("pc", entry.pc, cdb_pc);
            compare_field("data", entry.data, cdb_data);
            compare_field("exception", {31'b0, entry.exc}, {31'b0, cdb_exception});
        end
    endtask

    // Sampled mid-cycle, the transfer happens at the next rising edge
    always @(negedge clk) begin
        if (!reset && cdb_valid && cdb_ready) begin
            check_transfer();
        end
    end

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic report_test(input int start_errors);
        $display("%s: %s (%0d errors)", cur_test,
                 (error_count == start_errors) ? "passed" : "failed",
                 error_count - start_errors);
    endtask

    // The bus is idle and both units offer credit once reset is released
    task automatic test_reset_state();
        int start_errors;
        cur_test = "reset";
        start_errors = error_count;
        compare_field("cdb_valid", 32'd0, {31'b0, cdb_valid});
        compare_field("div ready", 32'd1, {31'b0, issue_div_ready});
        compare_field("mul ready", 32'd1, {31'b0, issue_mul_ready});
        report_test(start_errors);
    endtask

    task automatic test_division();
        int    start_errors;
        int    cycles;
        word_t a;
        word_t b;
        cur_test = "division";
        start_errors = error_count;
        cdb_ready = 1'b1;
        // An isolated divide first, to measure its latency
        issue_one(op_divu, 32'd1000, 32'd7);
        cycles = 1;
        while (!cdb_valid && cycles < drain_timeout) begin
            next_cycle(1);
            cycles++;
        end
        check_count++;
        assert (cdb_valid && cycles >= div_latency + 1) else begin
            $display("[ERROR] %s latency expected at least %0d actual %0d", cur_test,
                     div_latency + 1, cycles);
            error_count++;
        end
        wait_drain();
        for (int i = 0; i < 8; i++) begin
            a = rand_word(32);
            b = rand_word(32) >> rand_word(5);
            if (b == '0) b = 32'd1;
            issue_one(op_divu, a, b);
            issue_one(op_remu, a, b);
        end
        wait_drain();
        report_test(start_errors);
    endtask

    task automatic test_divide_zero();
        int    start_errors;
        word_t a;
        cur_test = "divide_zero";
        start_errors = error_count;
        a = rand_word(32) | 32'd1;
        issue_one(op_divu, a, '0);
        issue_one(op_remu, a, '0);
        issue_one(op_divu, '0, '0);
        issue_one(op_remu, '0, '0);
        wait_drain();
        report_test(start_errors);
    endtask

    task automatic test_multiply();
        int    start_errors;
        word_t a;
        word_t b;
        cur_test = "multiply";
        start_errors = error_count;
        for (int i = 0; i < 8; i++) begin
            a = rand_word(32);
            b = rand_word(32);
            issue_one(op_mul, a, b);
            issue_one(op_mulhu, a, b);
        end
        wait_drain();
        report_test(start_errors);
    endtask

    task automatic test_credits();
        int start_errors;
        int accepted;
        cur_test = "credits";
        start_errors = error_count;
        cdb_ready = 1'b0;
        accepted = 0;
        while (issue_div_ready && accepted < queue_depth + 2) begin
            issue_one(op_divu, rand_word(32), rand_word(16) + 32'd1);
            accepted++;
        end
        compare_field("accepted issues", queue_depth, accepted);
        cdb_ready = 1'b1;
        wait_drain();
        report_test(start_errors);
    endtask

    task automatic test_arbitration();
        int start_errors;
        cur_test = "arbitration";
        start_errors = error_count;
        cdb_ready = 1'b0;
        xfer_units.delete();
        for (int i = 0; i < queue_depth; i++) begin
            issue_one(op_remu, rand_word(32), rand_word(12) + 32'd3);
        end
        for (int i = 0; i < queue_depth; i++) begin
            issue_one(op_mul, rand_word(32), rand_word(32));
        end
        // The multiplier has used up its credits while the bus is stalled
        compare_field("mul ready", 32'd0, {31'b0, issue_mul_ready});
        // The last divide has left its pipeline after this many cycles
        next_cycle(div_latency + 2);
        cdb_ready = 1'b1;
        wait_drain();
        compare_field("transfer count", 2 * queue_depth, xfer_units.size());
        for (int i = 1; i < xfer_units.size(); i++) begin
            compare_field("unit of transfer", 1 - xfer_units[i-1], xfer_units[i]);
        end
        report_test(start_errors);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_op    = op_divu;
        issue_a     = '0;
        issue_b     = '0;
        issue_tag   = '0;
        issue_pc    = '0;
        cdb_ready   = 1'b1;
        lfsr_state  = 32'hc8e5893e;
        next_tag    = '0;
        cur_test    = "reset";
        error_count = 0;
        check_count = 0;
        next_cycle(8);
        reset = 1'b0;
        next_cycle(1);

        test_reset_state();
        test_division();
        test_divide_zero();
        test_multiply();
        test_credits();
        test_arbitration();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/muldiv_pkg.sv
hw/pipe_divider.sv
hw/pipe_multiplier.sv
hw/result_queue.sv
hw/cdb_arbiter.sv
hw/muldiv_cluster.sv
dv/tb_muldiv_cluster.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_muldiv_cluster -f files.f -o sim_muldiv \
    && ./obj_dir/sim_muldiv 2>&1 | tee sim.log \
    || exit 1
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
